/* files.f */
+incdir+test
verilog/core_pkg.sv
verilog/sequence_counter.sv
verilog/instruction_store.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/compute_core.sv
test/compute_core_tb.sv

/* test/compute_core_tb_tasks.svh */
`ifndef COMPUTE_CORE_TB_TASKS_SVH
`define COMPUTE_CORE_TB_TASKS_SVH

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic test_host_access();
    $display("Host register access in every channel");
    check_count++;
    if (host_read_valid !== 1'b0) begin
        error_count++;
        $display("Mismatch host_read_valid: expected 0, got %h", host_read_valid);
    end
    preload_registers();
    check_registers();
    // Valid lasts a single cycle
    @(negedge clock);
    check_count++;
    if (host_read_valid !== 1'b0) begin
        error_count++;
        $display("Mismatch host_read_valid: expected 0, got %h", host_read_valid);
    end
endtask

task automatic test_logic_ops();
    $display("Logic and arithmetic ops on four channels");
    preload_registers();
    program_words.delete();
    program_words.push_back(encode(LDC, 1, 0, 0, 16'(next_random())));
    program_words.push_back(encode(ADD, 4, 2, 3, 16'h0000));
    program_words.push_back(encode(SUB, 5, 2, 3, 16'h0000));
    program_words.push_back(encode(AND, 6, 2, 3, 16'h0000));
    program_words.push_back(encode(OR, 7, 2, 3, 16'h0000));
    program_words.push_back(encode(XOR, 8, 2, 3, 16'h0000));
    program_words.push_back(encode(ADD, 9, 1, 8, 16'h0000));
    // Negative constant checks the sign extension
    program_words.push_back(encode(LDC, 10, 0, 0, 16'h8001));
    program_words.push_back(encode(SUB, 11, 10, 1, 16'h0000));
    program_words.push_back(encode(STOP, 0, 0, 0, 16'h0000));
    load_program();
    run_and_wait(4);
    check_registers();
endtask

task automatic test_chained_ops();
    $display("Chained multiply and shifts");
    preload_registers();
    program_words.delete();
    program_words.push_back(encode(MUL, 10, 2, 3, 16'h0000));
    program_words.push_back(encode(SHL, 11, 10, 3, 16'h0000));
    program_words.push_back(encode(SHR, 12, 11, 2, 16'h0000));
    program_words.push_back(encode(NOP, 13, 1, 1, 16'h0000));
    program_words.push_back(encode(MUL, 13, 12, 10, 16'h0000));
    program_words.push_back(encode(LDC, 14, 0, 0, 16'd7));
    program_words.push_back(encode(SHR, 15, 13, 14, 16'h0000));
    program_words.push_back(encode(SHL, 2, 15, 14, 16'h0000));
    program_words.push_back(encode(STOP, 0, 0, 0, 16'h0000));
    load_program();
    run_and_wait(4);
    check_registers();
endtask

task automatic test_channel_count();
    $display("Partial channel count and invalid counts");
    preload_registers();
    program_words.delete();
    program_words.push_back(encode(ADD, 6, 1, 2, 16'h0000));
    program_words.push_back(encode(XOR, 7, 6, 3, 16'h0000));
    program_words.push_back(encode(STOP, 0, 0, 0, 16'h0000));
    load_program();
    run_and_wait(2);
    check_registers();
    run_and_wait(0);
    check_registers();
    run_and_wait(MAX_CHANNELS + 1);
    check_registers();
endtask

task automatic test_illegal_opcode();
    $display("Illegal opcode in the middle of a program");
    preload_registers();
    program_words.delete();
    program_words.push_back(encode(LDC, 1, 0, 0, 16'(next_random())));
    program_words.push_back(encode(ADD, 2, 3, 4, 16'h0000));
    program_words.push_back(encode(4'hb, 5, 6, 7, 16'h1234));
    program_words.push_back(encode(XOR, 5, 6, 7, 16'h0000));
    program_words.push_back(encode(STOP, 0, 0, 0, 16'h0000));
    load_program();
    run_and_wait(4);
    check_registers();
endtask

task automatic test_store_overrun();
    logic [3:0] op;
    $display("Program that runs off the end of the store");
    preload_registers();
    program_words.delete();
    for (int i = 0; i < PROGRAM_DEPTH; i++) begin
        op = 4'(next_random() % 10);
        program_words.push_back(encode(op, i % 16, (i + 3) % 16, (i + 7) % 16,
                                       16'(next_random())));
    end
    load_program();
    run_and_wait(4);
    check_registers();
    // A fresh short program must complete after the fault
    program_words.delete();
    program_words.push_back(encode(LDC, 3, 0, 0, 16'h7ff3));
    program_words.push_back(encode(ADD, 4, 3, 3, 16'h0000));
    program_words.push_back(encode(STOP, 0, 0, 0, 16'h0000));
    load_program();
    run_and_wait(3);
    check_registers();
endtask

`endif

/* test/compute_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module compute_core_tb
    import core_pkg::*;
();

    localparam int DATA_WIDTH = 32;
    localparam int PROGRAM_DEPTH = 64;
    localparam int MAX_CHANNELS = 4;
    localparam int COUNT_WIDTH = $clog2(MAX_CHANNELS + 1);
    localparam int ADDRESS_WIDTH = $clog2(MAX_CHANNELS) + REG_FIELD_WIDTH;
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH);
    localparam int REG_COUNT = MAX_CHANNELS * REGS_PER_CHANNEL;
    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_LIMIT = 1000;
    // Longest test is a full store at four channels plus register traffic
    localparam int TEST_COUNT = 6;
    localparam int TEST_BUDGET_CYCLES = 1500;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_COUNT * TEST_BUDGET_CYCLES;

    logic clock;
    logic reset;
    logic run;
    logic [COUNT_WIDTH-1:0] active_channels;
    logic program_write;
    logic [PC_WIDTH-1:0] program_address;
    logic [INSTRUCTION_WIDTH-1:0] program_data;
    logic host_write;
    logic host_read;
    logic [ADDRESS_WIDTH-1:0] host_address;
    logic [DATA_WIDTH-1:0] host_write_data;
    logic busy;
    logic done;
    logic fault;
    logic [DATA_WIDTH-1:0] host_read_data;
    logic host_read_valid;

    int error_count = 0;
    int check_count = 0;
    logic [31:0] lcg_state = 32'hac514bec;
    logic [DATA_WIDTH-1:0] model_regs [REG_COUNT];
    logic [INSTRUCTION_WIDTH-1:0] program_words [$];

    compute_core #(
        .DATA_WIDTH(DATA_WIDTH),
        .PROGRAM_DEPTH(PROGRAM_DEPTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [INSTRUCTION_WIDTH-1:0] encode(input logic [3:0] op,
            input int dest, input int src_a, input int src_b, input logic [15:0] imm);
        return {op, 4'(dest), 4'(src_a), 4'(src_b), imm};
    endfunction

    task automatic write_register(input int address, input logic [DATA_WIDTH-1:0] data);
        host_write = 1'b1;
        host_address = ADDRESS_WIDTH'(address);
        host_write_data = data;
        @(negedge clock);
        host_write = 1'b0;
    endtask

    // Data and valid are sampled one cycle after the read strobe
    task automatic read_register(input int address, output logic [DATA_WIDTH-1:0] data);
        host_read = 1'b1;
        host_address = ADDRESS_WIDTH'(address);
        @(negedge clock);
        host_read = 1'b0;
        check_count++;
        if (host_read_valid !== 1'b1) begin
            error_count++;
            $display("Mismatch host_read_valid: expected 1, got %h", host_read_valid);
        end
        data = host_read_data;
    endtask

    task automatic load_program();
        for (int i = 0; i < program_words.size(); i++) begin
            program_write = 1'b1;
            program_address = PC_WIDTH'(i);
            program_data = program_words[i];
            @(negedge clock);
        end
        program_write = 1'b0;
    endtask

    task automatic preload_registers();
        logic [DATA_WIDTH-1:0] value;
        for (int i = 0; i < REG_COUNT; i++) begin
            value = next_random();
            write_register(i, value);
            model_regs[i] = value;
        end
    endtask

    task automatic check_registers();
        logic [DATA_WIDTH-1:0] value;
        for (int i = 0; i < REG_COUNT; i++) begin
            read_register(i, value);
            check_count++;
            if (value !== model_regs[i]) begin
                error_count++;
                $display("Mismatch host_read_data[%h]: expected %h, got %h",
                         i, model_regs[i], value);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [DATA_WIDTH-1:0] expected_result(input logic [3:0] op,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
            input logic [15:0] imm);
        logic [2*DATA_WIDTH-1:0] product;
        product = a * b;
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR: return a | b;
            XOR: return a ^ b;
            MUL: return product[DATA_WIDTH-1:0];
            SHL: return a << b[4:0];
            SHR: return a >> b[4:0];
            LDC: return {{(DATA_WIDTH - 16){imm[15]}}, imm};
            default: return '0;
        endcase
    endfunction

    // Applies the program to the model and works out when done or fault appears,
    // counted in cycles from the first fetch
    task automatic predict_run(input int channels, output int cycles, output bit faults);
        int index;
        int ch;
        int base;
        bit finished;
        logic [3:0] op;
        logic [INSTRUCTION_WIDTH-1:0] word;
        cycles = 0;
        faults = 1'b0;
        finished = 1'b0;
        index = 0;
        if (channels < 1 || channels > MAX_CHANNELS) begin
            faults = 1'b1;
            finished = 1'b1;
        end
        while (!finished) begin
            word = program_words[index];
            op = word[31:28];
            if (op == STOP || (op >= 4'd10 && op <= 4'd14)) begin
                cycles += 3;
                faults = op != STOP;
                finished = 1'b1;
            end else begin
                for (ch = 0; ch < channels; ch++) begin
                    base = ch * REGS_PER_CHANNEL;
                    if (op != NOP) begin
                        model_regs[base + word[27:24]] = expected_result(op,
                            model_regs[base + word[23:20]], model_regs[base + word[19:16]],
                            word[15:0]);
                    end
                end
                // Fault at the last address takes the slot of the next fetch
                cycles += channels + 4;
                if (index == PROGRAM_DEPTH - 1) begin
                    faults = 1'b1;
                    finished = 1'b1;
                end else begin
                    index++;
                end
            end
        end
    endtask

    task automatic run_and_wait(input int channels);
        int expected_cycles;
        int cycles;
        bit expected_fault;
        predict_run(channels, expected_cycles, expected_fault);
        run = 1'b1;
        active_channels = COUNT_WIDTH'(channels);
        @(negedge clock);
        run = 1'b0;
        cycles = 0;
        check_count++;
        if (busy !== 1'b1) begin
            error_count++;
            $display("Mismatch busy: expected 1, got %h", busy);
        end
        while (!done && !fault && cycles < RUN_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        check_count++;
        if (!done && !fault) begin
            error_count++;
            $display("Run with %0d channels did not end within %0d cycles", channels, RUN_LIMIT);
        end else begin
            if (fault !== expected_fault) begin
                error_count++;
                $display("Mismatch fault: expected %h, got %h", expected_fault, fault);
            end
            if (done !== !expected_fault) begin
                error_count++;
                $display("Mismatch done: expected %h, got %h", !expected_fault, done);
            end
            if (cycles != expected_cycles) begin
                error_count++;
                $display("Mismatch run_cycles: expected %h, got %h", expected_cycles, cycles);
            end
        end
        @(negedge clock);
        check_count++;
        if (busy !== 1'b0) begin
            error_count++;
            $display("Mismatch busy: expected 0, got %h", busy);
        end
    endtask

    `include "compute_core_tb_tasks.svh"

    initial begin
        reset = 1'b1;
        run = 1'b0;
        active_channels = '0;
        program_write = 1'b0;
        program_address = '0;
        program_data = '0;
        host_write = 1'b0;
        host_read = 1'b0;
        host_address = '0;
        host_write_data = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        test_host_access();
        test_logic_ops();
        test_chained_ops();
        test_channel_count();
        test_illegal_opcode();
        test_store_overrun();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/compute_core.sv */
`timescale 1ns/100ps
`default_nettype none

module compute_core
    import core_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int PROGRAM_DEPTH = 64,
    parameter int MAX_CHANNELS = 4,
    localparam int CHANNEL_WIDTH = $clog2(MAX_CHANNELS),
    localparam int COUNT_WIDTH = $clog2(MAX_CHANNELS + 1),
    localparam int ADDRESS_WIDTH = CHANNEL_WIDTH + REG_FIELD_WIDTH,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH)
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic [COUNT_WIDTH-1:0] active_channels,
    input  logic program_write,
    input  logic [PC_WIDTH-1:0] program_address,
    input  logic [INSTRUCTION_WIDTH-1:0] program_data,
    input  logic host_write,
    input  logic host_read,
    input  logic [ADDRESS_WIDTH-1:0] host_address,
    input  logic [DATA_WIDTH-1:0] host_write_data,
    output logic busy,
    output logic done,
    output logic fault,
    output logic [DATA_WIDTH-1:0] host_read_data,
    output logic host_read_valid
);

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    logic fetch;
    logic issue;
    logic pc_clear;
    logic pc_step;
    logic channel_clear;
    logic channel_step;
    logic pc_last;
    logic [PC_WIDTH-1:0] program_counter;
    logic [CHANNEL_WIDTH-1:0] channel;

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////

    logic [INSTRUCTION_WIDTH-1:0] instruction;
    logic decoded_stop;
    logic decoded_illegal;
    logic decoded_nop;
    logic [ADDRESS_WIDTH-1:0] read_address_a;
    logic [ADDRESS_WIDTH-1:0] read_address_b;
    logic [DATA_WIDTH-1:0] read_data_a;
    logic [DATA_WIDTH-1:0] read_data_b;
    logic op_valid;
    opcode_t op_code;
    logic [ADDRESS_WIDTH-1:0] op_dest;
    logic [IMMEDIATE_WIDTH-1:0] op_immediate;
    logic write;
    logic [ADDRESS_WIDTH-1:0] write_address;
    logic [DATA_WIDTH-1:0] write_data;

    control_unit #(.MAX_CHANNELS(MAX_CHANNELS)) control0 (.*);

    sequence_counter #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) counter0 (.*);

    instruction_store #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) store0 (.*);

    decoder #(.MAX_CHANNELS(MAX_CHANNELS)) decoder0 (.*);

    // Operand reads land one cycle after issue, next to the operation stage
    register_file #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) registers0 (.*);

    alu #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) alu0 (.*);

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit
    import core_pkg::*;
#(
    parameter int MAX_CHANNELS = 4,
    localparam int CHANNEL_WIDTH = $clog2(MAX_CHANNELS),
    localparam int COUNT_WIDTH = $clog2(MAX_CHANNELS + 1),
    localparam int ADDRESS_WIDTH = CHANNEL_WIDTH + REG_FIELD_WIDTH
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic [COUNT_WIDTH-1:0] active_channels,
    input  logic pc_last,
    input  logic [CHANNEL_WIDTH-1:0] channel,
    input  logic decoded_stop,
    input  logic decoded_illegal,
    input  logic decoded_nop,
    input  logic write,
    input  logic [ADDRESS_WIDTH-1:0] write_address,
    output logic busy,
    output logic done,
    output logic fault,
    output logic fetch,
    output logic issue,
    output logic pc_clear,
    output logic pc_step,
    output logic channel_clear,
    output logic channel_step
);

    typedef enum logic [2:0] {IDLE, FETCH, WAIT, ISSUE, DRAIN, END} state_t;

    state_t state;
    state_t next_state;
    logic end_fault;
    logic next_end_fault;
    logic [COUNT_WIDTH-1:0] channel_count;
    logic [CHANNEL_WIDTH-1:0] last_channel;
    logic count_valid;
    logic start;
    logic last_issue;
    logic drain_count;
    logic drain_done;

    assign start = (state == IDLE) && run;
    assign count_valid = (active_channels != '0)
                      && (active_channels <= COUNT_WIDTH'(MAX_CHANNELS));
    assign last_channel = CHANNEL_WIDTH'(channel_count - 1'b1);

    //////////////////////////////////////////////////
    // Strobes to the counters and the pipeline
    //////////////////////////////////////////////////

    assign fetch = state == FETCH;
    assign issue = (state == ISSUE) && !decoded_stop && !decoded_illegal;
    assign last_issue = issue && (channel == last_channel);
    assign channel_step = issue && !last_issue;
    assign channel_clear = start || last_issue;
    assign pc_clear = start;

    // NOP writes nothing and ends its drain on the second DRAIN cycle
    assign drain_done = decoded_nop ? drain_count
        : write && (write_address[ADDRESS_WIDTH-1 -: CHANNEL_WIDTH] == last_channel);
    assign pc_step = (state == DRAIN) && drain_done && !pc_last;

    assign busy = state != IDLE;
    assign done = (state == END) && !end_fault;
    assign fault = (state == END) && end_fault;

    always_comb begin
        next_state = state;
        next_end_fault = end_fault;
        case (state)
            IDLE: begin
                if (run) begin
                    next_state = count_valid ? FETCH : END;
                    next_end_fault = !count_valid;
                end
            end
            FETCH: next_state = WAIT;
            WAIT: next_state = ISSUE;
            ISSUE: begin
                if (decoded_stop || decoded_illegal) begin
                    next_state = END;
                    next_end_fault = decoded_illegal;
                end else if (last_issue) begin
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                // Running off the end of the store is a fault
                if (drain_done) begin
                    next_state = pc_last ? END : FETCH;
                    next_end_fault = pc_last;
                end
            end
            END: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            end_fault <= 1'b0;
            channel_count <= '0;
            drain_count <= 1'b0;
        end else begin
            state <= next_state;
            end_fault <= next_end_fault;
            drain_count <= state == DRAIN;
            if (start) begin
                channel_count <= active_channels;
            end
        end
    end

    // Issue stays below the latched channel count
    issue_in_burst: assert property (
        @(posedge clock) disable iff (reset)
        issue |-> (channel < channel_count)
    ) else $error("Issue outside the channel burst");

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu
    import core_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_CHANNELS = 4,
    localparam int ADDRESS_WIDTH = $clog2(MAX_CHANNELS) + REG_FIELD_WIDTH
) (
    input  logic clock,
    input  logic reset,
    input  logic op_valid,
    input  opcode_t op_code,
    input  logic [ADDRESS_WIDTH-1:0] op_dest,
    input  logic [IMMEDIATE_WIDTH-1:0] op_immediate,
    input  logic [DATA_WIDTH-1:0] read_data_a,
    input  logic [DATA_WIDTH-1:0] read_data_b,
    output logic write,
    output logic [ADDRESS_WIDTH-1:0] write_address,
    output logic [DATA_WIDTH-1:0] write_data
);

    logic [DATA_WIDTH-1:0] result;
    logic signed [DATA_WIDTH-1:0] immediate_extended;
    logic [4:0] shift_amount;

    assign immediate_extended = $signed(op_immediate);
    assign shift_amount = read_data_b[4:0];

    // Product keeps only the low DATA_WIDTH bits
    always_comb begin
        case (op_code)
            ADD: result = read_data_a + read_data_b;
            SUB: result = read_data_a - read_data_b;
            AND: result = read_data_a & read_data_b;
            OR: result = read_data_a | read_data_b;
            XOR: result = read_data_a ^ read_data_b;
            MUL: result = read_data_a * read_data_b;
            SHL: result = read_data_a << shift_amount;
            SHR: result = read_data_a >> shift_amount;
            LDC: result = immediate_extended;
            default: result = '0;
        endcase
    end

    // Writeback stage
    always_ff @(posedge clock) begin
        if (reset) begin
            write <= 1'b0;
        end else begin
            write <= op_valid;
        end
    end

    always_ff @(posedge clock) begin
        write_address <= op_dest;
        write_data <= result;
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file
    import core_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_CHANNELS = 4,
    localparam int ADDRESS_WIDTH = $clog2(MAX_CHANNELS) + REG_FIELD_WIDTH,
    localparam int FILE_DEPTH = MAX_CHANNELS * REGS_PER_CHANNEL
) (
    input  logic clock,
    input  logic reset,
    input  logic [ADDRESS_WIDTH-1:0] read_address_a,
    input  logic [ADDRESS_WIDTH-1:0] read_address_b,
    input  logic write,
    input  logic [ADDRESS_WIDTH-1:0] write_address,
    input  logic [DATA_WIDTH-1:0] write_data,
    input  logic busy,
    input  logic host_write,
    input  logic host_read,
    input  logic [ADDRESS_WIDTH-1:0] host_address,
    input  logic [DATA_WIDTH-1:0] host_write_data,
    output logic [DATA_WIDTH-1:0] read_data_a,
    output logic [DATA_WIDTH-1:0] read_data_b,
    output logic [DATA_WIDTH-1:0] host_read_data,
    output logic host_read_valid
);

    logic [DATA_WIDTH-1:0] registers [FILE_DEPTH];

    // Writeback first, host only while the core is idle
    always_ff @(posedge clock) begin
        if (write) begin
            registers[write_address] <= write_data;
        end else if (host_write && !busy) begin
            registers[host_address] <= host_write_data;
        end
    end

    // Operand and host reads are both registered
    always_ff @(posedge clock) begin
        read_data_a <= registers[read_address_a];
        read_data_b <= registers[read_address_b];
        host_read_data <= registers[host_address];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            host_read_valid <= 1'b0;
        end else begin
            host_read_valid <= host_read;
        end
    end

    host_access_idle: assert property (
        @(posedge clock) disable iff (reset)
        busy |-> !(host_write || host_read)
    ) else $error("Host register access while the core is busy");

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder
    import core_pkg::*;
#(
    parameter int MAX_CHANNELS = 4,
    localparam int CHANNEL_WIDTH = $clog2(MAX_CHANNELS),
    localparam int ADDRESS_WIDTH = CHANNEL_WIDTH + REG_FIELD_WIDTH
) (
    input  logic clock,
    input  logic reset,
    input  logic [INSTRUCTION_WIDTH-1:0] instruction,
    input  logic issue,
    input  logic [CHANNEL_WIDTH-1:0] channel,
    output logic decoded_stop,
    output logic decoded_illegal,
    output logic decoded_nop,
    output logic [ADDRESS_WIDTH-1:0] read_address_a,
    output logic [ADDRESS_WIDTH-1:0] read_address_b,
    output logic op_valid,
    output opcode_t op_code,
    output logic [ADDRESS_WIDTH-1:0] op_dest,
    output logic [IMMEDIATE_WIDTH-1:0] op_immediate
);

    logic [OPCODE_WIDTH-1:0] raw_opcode;
    opcode_t opcode_q;
    logic [REG_FIELD_WIDTH-1:0] dest_q;
    logic [REG_FIELD_WIDTH-1:0] src_a_q;
    logic [REG_FIELD_WIDTH-1:0] src_b_q;
    logic [IMMEDIATE_WIDTH-1:0] immediate_q;

    assign raw_opcode = instruction[OPCODE_LSB +: OPCODE_WIDTH];

    //////////////////////////////////////////////////
    // Field and class stage
    //////////////////////////////////////////////////

    // The store holds its word, so these settle one cycle after the fetch lands
    always_ff @(posedge clock) begin
        opcode_q <= opcode_t'(raw_opcode);
        dest_q <= instruction[DEST_LSB +: REG_FIELD_WIDTH];
        src_a_q <= instruction[SRC_A_LSB +: REG_FIELD_WIDTH];
        src_b_q <= instruction[SRC_B_LSB +: REG_FIELD_WIDTH];
        immediate_q <= instruction[IMMEDIATE_LSB +: IMMEDIATE_WIDTH];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            decoded_stop <= 1'b0;
            decoded_illegal <= 1'b0;
            decoded_nop <= 1'b0;
        end else begin
            decoded_stop <= raw_opcode == STOP;
            decoded_illegal <= opcode_is_illegal(raw_opcode);
            decoded_nop <= raw_opcode == NOP;
        end
    end

    // Channel bank selected by the upper address bits
    assign read_address_a = {channel, src_a_q};
    assign read_address_b = {channel, src_b_q};

    //////////////////////////////////////////////////
    // Operation stage
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue && !decoded_nop;
        end
    end

    always_ff @(posedge clock) begin
        op_code <= opcode_q;
        op_dest <= {channel, dest_q};
        op_immediate <= immediate_q;
    end

endmodule

`default_nettype wire

/* verilog/instruction_store.sv */
`timescale 1ns/100ps
`default_nettype none

module instruction_store
    import core_pkg::*;
#(
    parameter int PROGRAM_DEPTH = 64,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH)
) (
    input  logic clock,
    input  logic program_write,
    input  logic [PC_WIDTH-1:0] program_address,
    input  logic [INSTRUCTION_WIDTH-1:0] program_data,
    input  logic fetch,
    input  logic [PC_WIDTH-1:0] program_counter,
    output logic [INSTRUCTION_WIDTH-1:0] instruction
);

    logic [INSTRUCTION_WIDTH-1:0] memory [PROGRAM_DEPTH];

    // Host load port
    always_ff @(posedge clock) begin
        if (program_write) begin
            memory[program_address] <= program_data;
        end
    end

    // Fetched word is held until the next fetch
    always_ff @(posedge clock) begin
        if (fetch) begin
            instruction <= memory[program_counter];
        end
    end

endmodule

`default_nettype wire

/* verilog/sequence_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module sequence_counter #(
    parameter int PROGRAM_DEPTH = 64,
    parameter int MAX_CHANNELS = 4,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH),
    localparam int CHANNEL_WIDTH = $clog2(MAX_CHANNELS)
) (
    input  logic clock,
    input  logic reset,
    input  logic pc_clear,
    input  logic pc_step,
    input  logic channel_clear,
    input  logic channel_step,
    output logic [PC_WIDTH-1:0] program_counter,
    output logic [CHANNEL_WIDTH-1:0] channel,
    output logic pc_last
);

    // Clear wins over step on both counters
    always_ff @(posedge clock) begin
        if (reset || pc_clear) begin
            program_counter <= '0;
        end else if (pc_step) begin
            program_counter <= program_counter + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || channel_clear) begin
            channel <= '0;
        end else if (channel_step) begin
            channel <= channel + 1'b1;
        end
    end

    assign pc_last = program_counter == PC_WIDTH'(PROGRAM_DEPTH - 1);

    // The burst must clear the channel instead of wrapping it
    channel_in_range: assert property (
        @(posedge clock) disable iff (reset)
        channel_step |-> (channel != CHANNEL_WIDTH'(MAX_CHANNELS - 1))
    ) else $error("Channel counter stepped past the last channel");

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Operation codes
    // Codes 10 to 14 carry no operation and are illegal
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        MUL  = 4'd6,
        SHL  = 4'd7,
        SHR  = 4'd8,
        LDC  = 4'd9,
        STOP = 4'd15
    } opcode_t;

    localparam int INSTRUCTION_WIDTH = 32;
    localparam int OPCODE_WIDTH = 4;
    localparam int REG_FIELD_WIDTH = 4;
    localparam int REGS_PER_CHANNEL = 16;
    localparam int IMMEDIATE_WIDTH = 16;

    // Field positions inside the instruction word
    localparam int OPCODE_LSB = 28;
    localparam int DEST_LSB = 24;
    localparam int SRC_A_LSB = 20;
    localparam int SRC_B_LSB = 16;
    localparam int IMMEDIATE_LSB = 0;

    function automatic logic opcode_is_illegal(input logic [OPCODE_WIDTH-1:0] code);
        return code inside {[4'd10 : 4'd14]};
    endfunction

endpackage

`default_nettype wire
